//--- vid_pkg.sv
`default_nettype none

package vid_pkg;

    // ============================================================
    // widths
    // ============================================================
    localparam int SYS_CTRL_W = 16;
    localparam int KEY_W      = 2;
    localparam int IR_CODE_W  = 16;
    localparam int IR_CNT_W   = 8;
    localparam int CONTROLS_W = 32;
    localparam int LED_W      = 8;

    // system control word bit positions
    localparam int CTRL_HSYNC_POL   = 8;
    localparam int CTRL_VSYNC_POL   = 9;
    localparam int CTRL_TESTPATTERN = 12;
    localparam int CTRL_FRAMELOCK   = 14;

    localparam int RESYNC_HOLD_CYCLES = 48; // led on-time after a resync

    typedef logic [KEY_W-1:0] key_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef enum logic [1:0] {OSD_BLACK, OSD_BLUE, OSD_YELLOW, OSD_WHITE} osd_color_t;

    // osd colors, indexed by osd_color_t
    localparam pixel_t OSD_PALETTE [4] = '{
        pixel_t'(24'h000000),
        pixel_t'(24'h0000ff),
        pixel_t'(24'hffff00),
        pixel_t'(24'hffffff)
    };

endpackage

`default_nettype wire

//--- sync_2ff.sv
`default_nettype none

// two flops against metastability on an async input
module sync_2ff #(
    parameter type   sync_t    = logic,
    parameter sync_t RESET_VAL = '0
) (
    input  wire   clk27,
    input  wire   sys_reset_n,
    input  sync_t d_i,
    output sync_t q_o
);

    sync_t meta_q; // first stage, may go metastable

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            meta_q <= RESET_VAL;
            q_o    <= RESET_VAL;
        end else begin
            meta_q <= d_i;
            q_o    <= meta_q;
        end
    end

endmodule

`default_nettype wire

//--- digitizer_capture.sv
`default_nettype none

module digitizer_capture
    import vid_pkg::*;
(
    input  wire    clk27,
    input  wire    sys_reset_n,
    input  pixel_t pixel_i,
    input  wire    de_i,
    input  wire    hsync_i,
    input  wire    vsync_i,
    input  wire    fid_i,
    input  wire    hsync_pol_i,   // 1 = raw hsync is active low
    input  wire    vsync_pol_i,
    input  wire    testpattern_i,
    output pixel_t pixel_o,
    output logic   de_o,
    output logic   hsync_o,
    output logic   vsync_o,
    output logic   fid_o,
    output logic   vs_flag_o
);

    // ============================================================
    // pixel bus, one register stage
    // ============================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            pixel_o <= '0;
            de_o    <= 1'b0;
        end else begin
            pixel_o <= pixel_i;
            de_o    <= de_i;
        end
    end

    // ============================================================
    // sync signals, async to clk27
    // ============================================================
    logic [2:0] sync_s; // {hsync, vsync, fid}
    logic       vsync_corr;

    sync_2ff #(
        .sync_t    (logic [2:0]),
        .RESET_VAL (3'b000)
    ) u_sync_hvf (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .d_i         ({hsync_i, vsync_i, fid_i}),
        .q_o         (sync_s)
    );

    assign fid_o      = sync_s[0];  // no polarity fix on fid
    assign vsync_corr = sync_s[1] ^ vsync_pol_i;

    // polarity fix, outputs active high from here on
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            hsync_o   <= 1'b0;
            vsync_o   <= 1'b0;
            vs_flag_o <= 1'b0;
        end else begin
            hsync_o   <= sync_s[2] ^ hsync_pol_i;
            vsync_o   <= vsync_corr;
            vs_flag_o <= testpattern_i ? 1'b0 : ~vsync_corr; // cpu sees no vsync on pattern
        end
    end

endmodule

`default_nettype wire

//--- osd_overlay.sv
`default_nettype none

module osd_overlay
    import vid_pkg::*;
(
    input  wire        clk27,
    input  wire        sys_reset_n,
    input  pixel_t     pixel_i,
    input  wire        hsync_i,
    input  wire        vsync_i,
    input  wire        de_i,
    input  wire        osd_enable_i,
    input  osd_color_t osd_color_i,
    output pixel_t     tx_d_o,
    output logic       tx_hs_o,
    output logic       tx_vs_o,
    output logic       tx_de_o
);

    pixel_t mix_q;
    logic   hs_q;
    logic   vs_q;
    logic   de_q;

    // stage 1: palette or scan converter pixel
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            mix_q <= '0;
            hs_q  <= 1'b0;
            vs_q  <= 1'b0;
            de_q  <= 1'b0;
        end else begin
            mix_q <= osd_enable_i ? OSD_PALETTE[osd_color_i] : pixel_i;
            hs_q  <= hsync_i;
            vs_q  <= vsync_i;
            de_q  <= de_i;
        end
    end

    // stage 2: output register towards the hdmi transmitter
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            tx_d_o  <= '0;
            tx_hs_o <= 1'b0;
            tx_vs_o <= 1'b0;
            tx_de_o <= 1'b0;
        end else begin
            tx_d_o  <= mix_q;
            tx_hs_o <= hs_q;
            tx_vs_o <= vs_q;
            tx_de_o <= de_q;
        end
    end

endmodule

`default_nettype wire

//--- status_led_driver.sv
`default_nettype none

module status_led_driver
    import vid_pkg::*;
(
    input  wire                   clk27,
    input  wire                   sys_reset_n,
    input  wire                   resync_strobe_i,
    input  wire                   framelock_i,
    input  wire  [IR_CODE_W-1:0]  ir_code_i,
    output logic [LED_W-1:0]      led_o
);

    localparam int CTR_W = $clog2(RESYNC_HOLD_CYCLES + 1);

    logic             strobe_s;
    logic             strobe_prev;
    logic             strobe_rise;
    logic [CTR_W-1:0] hold_ctr;

    // strobe comes from the scan converter clock domain
    sync_2ff #(
        .sync_t    (logic),
        .RESET_VAL (1'b0)
    ) u_sync_strobe (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .d_i         (resync_strobe_i),
        .q_o         (strobe_s)
    );

    assign strobe_rise = strobe_s & ~strobe_prev;

    // ============================================================
    // hold counter, keeps short strobes visible
    // ============================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            strobe_prev <= 1'b0;
            hold_ctr    <= '0;
        end else begin
            strobe_prev <= strobe_s;
            if (strobe_rise) begin
                hold_ctr <= CTR_W'(RESYNC_HOLD_CYCLES); // retrigger restarts the hold
            end else if (hold_ctr != '0) begin
                hold_ctr <= hold_ctr - CTR_W'(1);
            end
        end
    end

    // framelock on the upper half, no-ir-code, then resync activity
    assign led_o = {{4{framelock_i}},
                    (ir_code_i == '0),
                    {3{hold_ctr != '0}}};

endmodule

`default_nettype wire

//--- board_io_top.sv
`default_nettype none

module board_io_top
    import vid_pkg::*;
(
    input  wire                    clk27,
    input  wire                    sys_reset_n,
    // digitizer
    input  pixel_t                 isl_pixel_i,
    input  wire                    isl_de_i,
    input  wire                    isl_hsync_i,
    input  wire                    isl_vsync_i,
    input  wire                    isl_fid_i,
    // buttons, ir and cpu side
    input  key_t                   key_i,
    input  wire                    ir_rx_i,
    input  wire  [SYS_CTRL_W-1:0]  sys_ctrl_i,
    input  wire  [IR_CODE_W-1:0]   ir_code_i,
    input  wire  [IR_CNT_W-1:0]    ir_code_cnt_i,
    // scan converter and osd
    input  pixel_t                 sc_pixel_i,
    input  wire                    sc_hsync_i,
    input  wire                    sc_vsync_i,
    input  wire                    sc_de_i,
    input  wire                    osd_enable_i,
    input  osd_color_t             osd_color_i,
    input  wire                    resync_strobe_i,
    // outputs
    output pixel_t                 cap_pixel_o,
    output logic                   cap_de_o,
    output logic                   cap_hsync_o,
    output logic                   cap_vsync_o,
    output logic                   cap_fid_o,
    output logic                   vs_flag_o,
    output logic                   ir_rx_o,
    output logic [CONTROLS_W-1:0]  controls_o,
    output logic [LED_W-1:0]       led_o,
    output pixel_t                 hdmi_tx_d_o,
    output logic                   hdmi_tx_hs_o,
    output logic                   hdmi_tx_vs_o,
    output logic                   hdmi_tx_de_o
);

    localparam int CTRL_PAD_W = CONTROLS_W - KEY_W - IR_CNT_W - IR_CODE_W;

    key_t key_s; // buttons, active low

    // ============================================================
    // input capture
    // ============================================================
    digitizer_capture u_capture (
        .clk27         (clk27),
        .sys_reset_n   (sys_reset_n),
        .pixel_i       (isl_pixel_i),
        .de_i          (isl_de_i),
        .hsync_i       (isl_hsync_i),
        .vsync_i       (isl_vsync_i),
        .fid_i         (isl_fid_i),
        .hsync_pol_i   (sys_ctrl_i[CTRL_HSYNC_POL]),
        .vsync_pol_i   (sys_ctrl_i[CTRL_VSYNC_POL]),
        .testpattern_i (sys_ctrl_i[CTRL_TESTPATTERN]),
        .pixel_o       (cap_pixel_o),
        .de_o          (cap_de_o),
        .hsync_o       (cap_hsync_o),
        .vsync_o       (cap_vsync_o),
        .fid_o         (cap_fid_o),
        .vs_flag_o     (vs_flag_o)
    );

    // idle level of buttons and ir receiver is high
    sync_2ff #(.sync_t(key_t), .RESET_VAL('1)) u_sync_key (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .d_i         (key_i),
        .q_o         (key_s)
    );

    sync_2ff #(.sync_t(logic), .RESET_VAL(1'b1)) u_sync_ir (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .d_i         (ir_rx_i),
        .q_o         (ir_rx_o)
    );

    assign controls_o = {{CTRL_PAD_W{1'b0}}, key_s, ir_code_cnt_i, ir_code_i};

    // ============================================================
    // output stage and leds
    // ============================================================
    osd_overlay u_overlay (
        .clk27        (clk27),
        .sys_reset_n  (sys_reset_n),
        .pixel_i      (sc_pixel_i),
        .hsync_i      (sc_hsync_i),
        .vsync_i      (sc_vsync_i),
        .de_i         (sc_de_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .tx_d_o       (hdmi_tx_d_o),
        .tx_hs_o      (hdmi_tx_hs_o),
        .tx_vs_o      (hdmi_tx_vs_o),
        .tx_de_o      (hdmi_tx_de_o)
    );

    status_led_driver u_leds (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n),
        .resync_strobe_i (resync_strobe_i),
        .framelock_i     (sys_ctrl_i[CTRL_FRAMELOCK]),
        .ir_code_i       (ir_code_i),
        .led_o           (led_o)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk27_o,
    output logic sys_reset_n_o
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;

    initial begin
        clk27_o = 1'b0;
        forever #2 clk27_o = ~clk27_o; // 4 ns period
    end

    // release on a falling edge, like all other stimulus
    initial begin
        sys_reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk27_o);
        @(negedge clk27_o);
        sys_reset_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_board_io.sv
`default_nettype none

module tb_board_io
    import vid_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 2000; // tests need about 300 cycles

    logic                  clk27;
    logic                  sys_reset_n;
    pixel_t                isl_pixel;
    logic                  isl_de, isl_hsync, isl_vsync, isl_fid;
    key_t                  key;
    logic                  ir_rx;
    logic [SYS_CTRL_W-1:0] sys_ctrl;
    logic [IR_CODE_W-1:0]  ir_code;
    logic [IR_CNT_W-1:0]   ir_cnt;
    pixel_t                sc_pixel;
    logic                  sc_hsync, sc_vsync, sc_de, osd_enable;
    osd_color_t            osd_color;
    logic                  resync_strobe;
    pixel_t                cap_pixel;
    logic                  cap_de, cap_hsync, cap_vsync, cap_fid, vs_flag, ir_rx_out;
    logic [CONTROLS_W-1:0] controls;
    logic [LED_W-1:0]      led;
    pixel_t                hdmi_d;
    logic                  hdmi_hs, hdmi_vs, hdmi_de;
    int                    cycle_count = 0;

    tb_clock_gen u_clk (.clk27_o(clk27), .sys_reset_n_o(sys_reset_n));

    board_io_top uut (
        .clk27(clk27), .sys_reset_n(sys_reset_n),
        .isl_pixel_i(isl_pixel), .isl_de_i(isl_de), .isl_hsync_i(isl_hsync),
        .isl_vsync_i(isl_vsync), .isl_fid_i(isl_fid), .key_i(key), .ir_rx_i(ir_rx),
        .sys_ctrl_i(sys_ctrl), .ir_code_i(ir_code), .ir_code_cnt_i(ir_cnt),
        .sc_pixel_i(sc_pixel), .sc_hsync_i(sc_hsync), .sc_vsync_i(sc_vsync),
        .sc_de_i(sc_de), .osd_enable_i(osd_enable), .osd_color_i(osd_color),
        .resync_strobe_i(resync_strobe),
        .cap_pixel_o(cap_pixel), .cap_de_o(cap_de), .cap_hsync_o(cap_hsync),
        .cap_vsync_o(cap_vsync), .cap_fid_o(cap_fid), .vs_flag_o(vs_flag),
        .ir_rx_o(ir_rx_out), .controls_o(controls), .led_o(led),
        .hdmi_tx_d_o(hdmi_d), .hdmi_tx_hs_o(hdmi_hs), .hdmi_tx_vs_o(hdmi_vs),
        .hdmi_tx_de_o(hdmi_de)
    );

    // ============================================================
    // helpers and compare tasks
    // ============================================================
    task automatic wait_fall();
        @(negedge clk27);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run aborted");
    endtask

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "pixel compare failed");
        end
    endtask

    task automatic check_bits(input string name, input logic [CONTROLS_W-1:0] exp,
                              input logic [CONTROLS_W-1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "vector compare failed");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %b actual %b", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "bit compare failed");
        end
    endtask

    function automatic pixel_t rand_pixel();
        logic [31:0] w;
        w = $urandom;
        return pixel_t'(w[23:0]);
    endfunction

    // black, blue, yellow, white
    function automatic pixel_t palette_color(input osd_color_t c);
        case (c)
            OSD_BLACK:  return pixel_t'(24'h000000);
            OSD_BLUE:   return pixel_t'(24'h0000ff);
            OSD_YELLOW: return pixel_t'(24'hffff00);
            default:    return pixel_t'(24'hffffff);
        endcase
    endfunction

    task automatic init_inputs();
        isl_pixel = '0;
        {isl_de, isl_hsync, isl_vsync, isl_fid} = 4'b0000;
        key       = '1;    // buttons idle high
        ir_rx     = 1'b1;
        sys_ctrl  = '0;
        ir_code   = 16'h0001;
        ir_cnt    = '0;
        sc_pixel  = '0;
        {sc_hsync, sc_vsync, sc_de, osd_enable} = 4'b0000;
        osd_color = OSD_BLACK;
        resync_strobe = 1'b0;
    endtask

    // ============================================================
    // directed tests
    // ============================================================
    task automatic test_reset_state();
        check_pixel("reset hdmi data", pixel_t'(24'h0), hdmi_d);
        check_bit("reset hdmi hs", 1'b0, hdmi_hs);
        check_bit("reset hdmi vs", 1'b0, hdmi_vs);
        check_bit("reset hdmi de", 1'b0, hdmi_de);
        check_pixel("reset cap pixel", pixel_t'(24'h0), cap_pixel);
        check_bit("reset cap de", 1'b0, cap_de);
        check_bit("reset cap hsync", 1'b0, cap_hsync);
        check_bit("reset cap vsync", 1'b0, cap_vsync);
        check_bit("reset cap fid", 1'b0, cap_fid);
        check_bit("reset vs flag", 1'b0, vs_flag);
        check_bit("reset ir rx", 1'b1, ir_rx_out);
        check_bits("reset controls", {6'b000000, 2'b11, 8'h00, 16'h0001}, controls);
        check_bits("reset leds", CONTROLS_W'(8'h00), CONTROLS_W'(led));
    endtask

    task automatic test_overlay();
        pixel_t      exp_d [40];
        logic [2:0]  exp_sync [40]; // {hs, vs, de}
        logic [31:0] w;
        for (int i = 0; i < 42; i++) begin
            wait_fall();
            if (i >= 2) begin // two pixels still in flight
                check_pixel("overlay data", exp_d[i-2], hdmi_d);
                check_bit("overlay hs", exp_sync[i-2][2], hdmi_hs);
                check_bit("overlay vs", exp_sync[i-2][1], hdmi_vs);
                check_bit("overlay de", exp_sync[i-2][0], hdmi_de);
            end
            if (i < 40) begin
                w = $urandom;
                sc_pixel = rand_pixel();
                {sc_hsync, sc_vsync, sc_de, osd_enable} = w[3:0];
                osd_color = osd_color_t'(w[5:4]);
                exp_d[i] = osd_enable ? palette_color(osd_color) : sc_pixel;
                exp_sync[i] = w[3:1];
            end
        end
    endtask

    task automatic test_capture();
        pixel_t      exp_px;
        logic        exp_de;
        logic        exp_vs;
        logic [31:0] w;
        for (int i = 0; i < 11; i++) begin
            wait_fall();
            if (i >= 1) begin
                check_pixel("capture pixel", exp_px, cap_pixel);
                check_bit("capture de", exp_de, cap_de);
            end
            w = $urandom;
            isl_pixel = rand_pixel();
            isl_de = w[0];
            exp_px = isl_pixel;
            exp_de = isl_de;
        end
        // every polarity, test pattern and raw sync combination
        for (int mode = 0; mode < 32; mode++) begin
            wait_fall();
            w = $urandom;
            sys_ctrl = '0;
            sys_ctrl[CTRL_HSYNC_POL] = mode[4];
            sys_ctrl[CTRL_VSYNC_POL] = mode[3];
            sys_ctrl[CTRL_TESTPATTERN] = mode[2];
            {isl_hsync, isl_vsync, isl_fid} = {mode[1], mode[0], w[0]};
            exp_vs = mode[0] ^ mode[3];
            repeat (4) wait_fall();
            check_bit("capture hsync", mode[1] ^ mode[4], cap_hsync);
            check_bit("capture vsync", exp_vs, cap_vsync);
            check_bit("capture fid", w[0], cap_fid);
            check_bit("capture vs flag", mode[2] ? 1'b0 : ~exp_vs, vs_flag);
        end
    endtask

    task automatic test_controls();
        logic [31:0] w;
        for (int i = 0; i < 8; i++) begin
            wait_fall();
            w = $urandom;
            key = key_t'(w[1:0]);
            ir_cnt = w[9:2];
            ir_rx = w[10];
            ir_code = w[31:16];
            repeat (3) wait_fall();
            check_bits("controls word", {6'b000000, w[1:0], w[9:2], w[31:16]}, controls);
            check_bit("ir rx", w[10], ir_rx_out);
        end
    endtask

    task automatic test_resync_leds();
        int n;
        wait_fall();
        sys_ctrl = '0;
        ir_code = 16'h1234;
        resync_strobe = 1'b1;
        wait_fall();
        resync_strobe = 1'b0;
        n = 1;
        while (led[2:0] != 3'b111) begin
            if (n >= 5) begin
                abort_run("resync leds did not light within 5 cycles of the strobe");
            end
            wait_fall();
            n++;
        end
        while (n < RESYNC_HOLD_CYCLES - 2) begin
            wait_fall();
            n++;
        end
        check_bits("resync hold", CONTROLS_W'(8'h07), CONTROLS_W'(led));
        while (n < RESYNC_HOLD_CYCLES + 6) begin
            wait_fall();
            n++;
        end
        check_bits("resync expired", CONTROLS_W'(8'h00), CONTROLS_W'(led));
        sys_ctrl[CTRL_FRAMELOCK] = 1'b1;
        ir_code = '0;
        wait_fall();
        check_bits("framelock and no code", CONTROLS_W'(8'hf8), CONTROLS_W'(led));
    endtask

    always @(posedge clk27) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, tests did not complete in %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(32'hc8e1_b481));
        init_inputs();
        @(posedge sys_reset_n);
        test_reset_state();
        test_overlay();
        test_capture();
        test_controls();
        test_resync_leds();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
vid_pkg.sv
sync_2ff.sv
digitizer_capture.sv
osd_overlay.sv
status_led_driver.sv
board_io_top.sv
tb_clock_gen.sv
tb_board_io.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_board_io -f compile.f --Mdir obj_dir

./obj_dir/Vtb_board_io > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
grep -q "Finished with no errors" sim.log
echo "simulation passed"
